// ==== sim.f ====
+incdir+tb
src/perf_pkg.sv
src/dcr_regs.sv
src/mem_traffic_counters.sv
src/mem_latency_tracker.sv
src/perf_read_port.sv
src/core_mem_perf_top.sv
tb/tb_core_mem_perf.sv

// ==== src/core_mem_perf_top.sv ====
`timescale 1ns/10ps

module core_mem_perf_top (
    input  logic                                      clk,
    input  logic                                      reset,
    input  perf_pkg::dcr_write_t                      dcr_write,
    input  perf_pkg::icache_mon_t                     icache_mon,
    input  perf_pkg::dcache_mon_t                     dcache_mon,
    input  logic                                      perf_rd_req,
    input  logic [perf_pkg::PERF_RD_ADDR_BITS-1:0]    perf_rd_addr,
    output logic                                      perf_rd_ack,
    output logic [perf_pkg::PERF_RD_DATA_BITS-1:0]    perf_rd_data
);
    import perf_pkg::*;

    logic                     count_en;
    logic                     clear;
    logic [LANE_CNT_BITS-1:0] rd_req_count;
    logic [LANE_CNT_BITS-1:0] rd_rsp_count;
    wire perf_counts_t        counts;

    dcr_regs u_dcr_regs (
        .clk       (clk),
        .reset     (reset),
        .dcr_write (dcr_write),
        .count_en  (count_en),
        .clear     (clear)
    );

    mem_traffic_counters u_traffic (
        .clk          (clk),
        .reset        (reset),
        .count_en     (count_en),
        .clear        (clear),
        .icache_mon   (icache_mon),
        .dcache_mon   (dcache_mon),
        .rd_req_count (rd_req_count),
        .rd_rsp_count (rd_rsp_count),
        .ifetches     (counts.ifetches),
        .loads        (counts.loads),
        .stores       (counts.stores)
    );

    // Latency follows the read counts from the traffic block
    mem_latency_tracker u_latency (
        .clk          (clk),
        .reset        (reset),
        .count_en     (count_en),
        .clear        (clear),
        .icache_mon   (icache_mon),
        .rd_req_count (rd_req_count),
        .rd_rsp_count (rd_rsp_count),
        .ifetch_lat   (counts.ifetch_lat),
        .load_lat     (counts.load_lat)
    );

    perf_read_port u_read_port (
        .clk          (clk),
        .reset        (reset),
        .counts       (counts),
        .perf_rd_req  (perf_rd_req),
        .perf_rd_addr (perf_rd_addr),
        .perf_rd_ack  (perf_rd_ack),
        .perf_rd_data (perf_rd_data)
    );

endmodule

// ==== src/dcr_regs.sv ====
`timescale 1ns/10ps

module dcr_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  perf_pkg::dcr_write_t dcr_write,
    output logic                 count_en,
    output logic                 clear
);
    import perf_pkg::*;

    logic [DCR_DATA_BITS-1:0] mpm_class;
    logic                     class_wr;
    logic                     clear_wr;

    assign class_wr = dcr_write.valid && (dcr_write.addr == DCR_MPM_CLASS);
    assign clear_wr = dcr_write.valid && (dcr_write.addr == DCR_PERF_CLEAR);

    // Performance class register
    always_ff @(posedge clk) begin
        if (reset) begin
            mpm_class <= '0;
        end else if (class_wr) begin
            mpm_class <= dcr_write.data;
        end
    end

    // One-cycle pulse, counters zero on the following edge
    always_ff @(posedge clk) begin
        if (reset) begin
            clear <= 1'b0;
        end else begin
            clear <= clear_wr;
        end
    end

    assign count_en = (mpm_class == MPM_CLASS_CORE);

endmodule

// ==== src/mem_latency_tracker.sv ====
`timescale 1ns/10ps

module mem_latency_tracker (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  count_en,
    input  logic                                  clear,
    input  perf_pkg::icache_mon_t                 icache_mon,
    input  logic [perf_pkg::LANE_CNT_BITS-1:0]    rd_req_count,
    input  logic [perf_pkg::LANE_CNT_BITS-1:0]    rd_rsp_count,
    output logic [perf_pkg::PERF_CTR_BITS-1:0]    ifetch_lat,
    output logic [perf_pkg::PERF_CTR_BITS-1:0]    load_lat
);
    import perf_pkg::*;

    logic                              icache_req_fire;
    logic                              icache_rsp_fire;
    logic signed [PENDING_BITS-1:0]    icache_pending;
    logic signed [PENDING_BITS-1:0]    dcache_pending;
    logic signed [PERF_CTR_BITS-1:0]   icache_pending_ext;
    logic signed [PERF_CTR_BITS-1:0]   dcache_pending_ext;

    assign icache_req_fire = icache_mon.req_valid && icache_mon.req_ready;
    assign icache_rsp_fire = icache_mon.rsp_valid && icache_mon.rsp_ready;

    // Outstanding reads, never gated or cleared
    always_ff @(posedge clk) begin
        if (reset) begin
            icache_pending <= '0;
            dcache_pending <= '0;
        end else begin
            icache_pending <= icache_pending
                              + PENDING_BITS'(icache_req_fire)
                              - PENDING_BITS'(icache_rsp_fire);
            dcache_pending <= dcache_pending
                              + PENDING_BITS'(rd_req_count)
                              - PENDING_BITS'(rd_rsp_count);
        end
    end

    // Sign extend so a transient negative count subtracts
    assign icache_pending_ext = icache_pending;
    assign dcache_pending_ext = dcache_pending;

    // Sums use the pending value held before the edge
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            ifetch_lat <= '0;
            load_lat   <= '0;
        end else if (count_en) begin
            ifetch_lat <= ifetch_lat + icache_pending_ext;
            load_lat   <= load_lat + dcache_pending_ext;
        end
    end

endmodule

// ==== src/mem_traffic_counters.sv ====
`timescale 1ns/10ps

module mem_traffic_counters (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  count_en,
    input  logic                                  clear,
    input  perf_pkg::icache_mon_t                 icache_mon,
    input  perf_pkg::dcache_mon_t                 dcache_mon,
    output logic [perf_pkg::LANE_CNT_BITS-1:0]    rd_req_count,
    output logic [perf_pkg::LANE_CNT_BITS-1:0]    rd_rsp_count,
    output logic [perf_pkg::PERF_CTR_BITS-1:0]    ifetches,
    output logic [perf_pkg::PERF_CTR_BITS-1:0]    loads,
    output logic [perf_pkg::PERF_CTR_BITS-1:0]    stores
);
    import perf_pkg::*;

    logic                       ifetch_fire;
    logic [DCACHE_NUM_REQS-1:0] rd_req_fire;
    logic [DCACHE_NUM_REQS-1:0] wr_req_fire;
    logic [DCACHE_NUM_REQS-1:0] rsp_fire;
    logic [LANE_CNT_BITS-1:0]   wr_req_count;

    assign ifetch_fire = icache_mon.req_valid && icache_mon.req_ready;

    // Per-lane fires, split on the read/write bit
    for (genvar i = 0; i < DCACHE_NUM_REQS; i++) begin : g_lane
        assign rd_req_fire[i] = dcache_mon[i].req_valid && dcache_mon[i].req_ready
                                && !dcache_mon[i].req_rw;
        assign wr_req_fire[i] = dcache_mon[i].req_valid && dcache_mon[i].req_ready
                                && dcache_mon[i].req_rw;
        assign rsp_fire[i]    = dcache_mon[i].rsp_valid && dcache_mon[i].rsp_ready;
    end

    // Popcounts over the lanes
    always_comb begin
        rd_req_count = '0;
        wr_req_count = '0;
        rd_rsp_count = '0;
        for (int i = 0; i < DCACHE_NUM_REQS; i++) begin
            rd_req_count = rd_req_count + LANE_CNT_BITS'(rd_req_fire[i]);
            wr_req_count = wr_req_count + LANE_CNT_BITS'(wr_req_fire[i]);
            rd_rsp_count = rd_rsp_count + LANE_CNT_BITS'(rsp_fire[i]);
        end
    end

    // Clear takes priority over this cycle's fires
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            ifetches <= '0;
            loads    <= '0;
            stores   <= '0;
        end else if (count_en) begin
            ifetches <= ifetches + PERF_CTR_BITS'(ifetch_fire);
            loads    <= loads + PERF_CTR_BITS'(rd_req_count);
            stores   <= stores + PERF_CTR_BITS'(wr_req_count);
        end
    end

endmodule

// ==== src/perf_pkg.sv ====
package perf_pkg;

    // Data cache lanes observed by the monitor
    localparam int DCACHE_NUM_REQS = 4;

    localparam int PERF_CTR_BITS = 44;
    localparam int LANE_CNT_BITS = $clog2(DCACHE_NUM_REQS + 1);
    localparam int PENDING_BITS = 16;

    localparam int DCR_ADDR_BITS = 12;
    localparam int DCR_DATA_BITS = 32;

    // DCR map
    localparam logic [DCR_ADDR_BITS-1:0] DCR_MPM_CLASS = 12'h003;
    localparam logic [DCR_ADDR_BITS-1:0] DCR_PERF_CLEAR = 12'h004;

    // Class value that turns the memory counters on
    localparam logic [DCR_DATA_BITS-1:0] MPM_CLASS_CORE = 32'd1;

    localparam int PERF_RD_ADDR_BITS = 3;
    localparam int PERF_RD_DATA_BITS = 64;

    // Read port counter select
    localparam logic [PERF_RD_ADDR_BITS-1:0] RD_IFETCHES = 3'd0;
    localparam logic [PERF_RD_ADDR_BITS-1:0] RD_LOADS = 3'd1;
    localparam logic [PERF_RD_ADDR_BITS-1:0] RD_STORES = 3'd2;
    localparam logic [PERF_RD_ADDR_BITS-1:0] RD_IFETCH_LAT = 3'd3;
    localparam logic [PERF_RD_ADDR_BITS-1:0] RD_LOAD_LAT = 3'd4;

    typedef struct packed {
        logic                     valid;
        logic [DCR_ADDR_BITS-1:0] addr;
        logic [DCR_DATA_BITS-1:0] data;
    } dcr_write_t;

    // Instruction cache handshake bits
    typedef struct packed {
        logic req_valid;
        logic req_ready;
        logic rsp_valid;
        logic rsp_ready;
    } icache_mon_t;

    // One data cache lane, req_rw high for a store
    typedef struct packed {
        logic req_valid;
        logic req_rw;
        logic req_ready;
        logic rsp_valid;
        logic rsp_ready;
    } dcache_lane_mon_t;

    typedef dcache_lane_mon_t [DCACHE_NUM_REQS-1:0] dcache_mon_t;

    typedef struct packed {
        logic [PERF_CTR_BITS-1:0] ifetches;
        logic [PERF_CTR_BITS-1:0] loads;
        logic [PERF_CTR_BITS-1:0] stores;
        logic [PERF_CTR_BITS-1:0] ifetch_lat;
        logic [PERF_CTR_BITS-1:0] load_lat;
    } perf_counts_t;

endpackage

// ==== src/perf_read_port.sv ====
`timescale 1ns/10ps

module perf_read_port (
    input  logic                                      clk,
    input  logic                                      reset,
    input  perf_pkg::perf_counts_t                    counts,
    input  logic                                      perf_rd_req,
    input  logic [perf_pkg::PERF_RD_ADDR_BITS-1:0]    perf_rd_addr,
    output logic                                      perf_rd_ack,
    output logic [perf_pkg::PERF_RD_DATA_BITS-1:0]    perf_rd_data
);
    import perf_pkg::*;

    logic [PERF_RD_DATA_BITS-1:0] rd_sel;
    logic                         rd_start;

    // Counter select, zero-extended
    always_comb begin
        case (perf_rd_addr)
            RD_IFETCHES:   rd_sel = PERF_RD_DATA_BITS'(counts.ifetches);
            RD_LOADS:      rd_sel = PERF_RD_DATA_BITS'(counts.loads);
            RD_STORES:     rd_sel = PERF_RD_DATA_BITS'(counts.stores);
            RD_IFETCH_LAT: rd_sel = PERF_RD_DATA_BITS'(counts.ifetch_lat);
            RD_LOAD_LAT:   rd_sel = PERF_RD_DATA_BITS'(counts.load_lat);
            default:       rd_sel = '0;
        endcase
    end

    // New request only once the previous ack has dropped
    assign rd_start = perf_rd_req && !perf_rd_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            perf_rd_ack <= 1'b0;
        end else if (rd_start) begin
            perf_rd_ack <= 1'b1;
        end else if (!perf_rd_req) begin
            perf_rd_ack <= 1'b0;
        end
    end

    // Snapshot held while ack is high
    always_ff @(posedge clk) begin
        if (rd_start) begin
            perf_rd_data <= rd_sel;
        end
    end

endmodule

// ==== tb/tb_tasks.svh ====
task automatic write_dcr(input logic [DCR_ADDR_BITS-1:0] wr_addr,
                         input logic [DCR_DATA_BITS-1:0] wr_data);
    @(posedge clk);
    dcr_write <= '{valid: 1'b1, addr: wr_addr, data: wr_data};
    @(posedge clk);
    dcr_write <= '0;
endtask

task automatic drive_cycle(input icache_mon_t ic, input dcache_mon_t dc);
    @(posedge clk);
    icache_mon <= ic;
    dcache_mon <= dc;
endtask

task automatic idle_cycles(input int n);
    repeat (n) drive_cycle('0, '0);
endtask

// Responses for these requests come later from drain_reads
task automatic drive_random_traffic(input int cycles);
    icache_mon_t ic;
    dcache_mon_t dc;
    for (int c = 0; c < cycles; c++) begin
        rng_state = xorshift32(rng_state);
        ic = '0;
        dc = '0;
        ic.req_valid = rng_state[0];
        ic.req_ready = rng_state[1];
        if (ic.req_valid && ic.req_ready) begin
            icache_outstanding++;
        end
        for (int i = 0; i < DCACHE_NUM_REQS; i++) begin
            dc[i].req_valid = rng_state[4 + 3*i];
            dc[i].req_ready = rng_state[5 + 3*i];
            dc[i].req_rw    = rng_state[6 + 3*i];
            if (dc[i].req_valid && dc[i].req_ready && !dc[i].req_rw) begin
                dcache_outstanding++;
            end
        end
        drive_cycle(ic, dc);
    end
    idle_cycles(1);
endtask

task automatic drain_reads();
    icache_mon_t ic;
    dcache_mon_t dc;
    while (icache_outstanding > 0 || dcache_outstanding > 0) begin
        ic = '0;
        dc = '0;
        if (icache_outstanding > 0) begin
            ic.rsp_valid = 1'b1;
            ic.rsp_ready = 1'b1;
            icache_outstanding--;
        end
        for (int i = 0; i < DCACHE_NUM_REQS; i++) begin
            if (dcache_outstanding > 0) begin
                dc[i].rsp_valid = 1'b1;
                dc[i].rsp_ready = 1'b1;
                dcache_outstanding--;
            end
        end
        drive_cycle(ic, dc);
    end
    idle_cycles(1);
endtask

task automatic read_counter(input logic [PERF_RD_ADDR_BITS-1:0] addr, input int hold_cycles);
    logic [PERF_RD_DATA_BITS-1:0] exp_data;
    int waited;
    waited = 0;
    @(posedge clk);
    while (perf_rd_ack !== 1'b0 && waited < HANDSHAKE_LIMIT) begin
        @(posedge clk);
        waited++;
    end
    check_count++;
    assert (perf_rd_ack === 1'b0) else begin
        $display("Read of address %0d could not start, ack still high from the last read", addr);
        error_count++;
    end
    perf_rd_addr <= addr;
    perf_rd_req <= 1'b1;
    @(posedge clk);
    // Snapshot holds the counters from before this edge
    exp_data = expected_count(addr);
    waited = 0;
    do begin
        @(posedge clk);
        waited++;
    end while (perf_rd_ack !== 1'b1 && waited < HANDSHAKE_LIMIT);
    check_count++;
    assert (perf_rd_ack === 1'b1) else begin
        $display("Read of address %0d timed out waiting for ack to rise", addr);
        error_count++;
        perf_rd_req <= 1'b0;
        return;
    end
    check_count++;
    assert (perf_rd_data === exp_data) else begin
        $display("[FAIL] perf_rd_data addr %0d: expected %h, got %h", addr, exp_data,
                 perf_rd_data);
        error_count++;
    end
    for (int h = 0; h < hold_cycles; h++) begin
        @(posedge clk);
        check_count++;
        assert (perf_rd_ack === 1'b1 && perf_rd_data === exp_data) else begin
            $display("[FAIL] perf_rd_ack/perf_rd_data while req held: expected %h/%h, got %h/%h",
                     1'b1, exp_data, perf_rd_ack, perf_rd_data);
            error_count++;
        end
    end
    perf_rd_req <= 1'b0;
    @(posedge clk);
    // Ack may only fall once req has been seen low
    check_count++;
    assert (perf_rd_ack === 1'b1) else begin
        $display("[FAIL] perf_rd_ack before req was sampled low: expected %h, got %h",
                 1'b1, perf_rd_ack);
        error_count++;
    end
    waited = 0;
    do begin
        @(posedge clk);
        waited++;
    end while (perf_rd_ack !== 1'b0 && waited < HANDSHAKE_LIMIT);
    check_count++;
    assert (perf_rd_ack === 1'b0) else begin
        $display("Read of address %0d timed out waiting for ack to fall", addr);
        error_count++;
    end
endtask

task automatic read_all_counters();
    read_counter(RD_IFETCHES, 0);
    read_counter(RD_LOADS, 0);
    read_counter(RD_STORES, 0);
    read_counter(RD_IFETCH_LAT, 0);
    read_counter(RD_LOAD_LAT, 0);
endtask

task automatic counting_disabled();
    drive_random_traffic(32);
    drain_reads();
    read_all_counters();
endtask

task automatic traffic_counts();
    write_dcr(DCR_MPM_CLASS, MPM_CLASS_CORE);
    drive_random_traffic(100);
    drain_reads();
    read_all_counters();
endtask

// One fetch and two loads released at different times
task automatic latency_spans();
    icache_mon_t ic;
    dcache_mon_t dc;
    write_dcr(DCR_PERF_CLEAR, '0);
    ic = '0;
    dc = '0;
    ic.req_valid = 1'b1;
    ic.req_ready = 1'b1;
    dc[0].req_valid = 1'b1;
    dc[0].req_ready = 1'b1;
    dc[1].req_valid = 1'b1;
    dc[1].req_ready = 1'b1;
    drive_cycle(ic, dc);
    idle_cycles(6);
    ic = '0;
    dc = '0;
    ic.rsp_valid = 1'b1;
    ic.rsp_ready = 1'b1;
    dc[0].rsp_valid = 1'b1;
    dc[0].rsp_ready = 1'b1;
    drive_cycle(ic, dc);
    idle_cycles(3);
    dc = '0;
    dc[1].rsp_valid = 1'b1;
    dc[1].rsp_ready = 1'b1;
    drive_cycle('0, dc);
    idle_cycles(2);
    read_counter(RD_IFETCH_LAT, 0);
    read_counter(RD_LOAD_LAT, 0);
endtask

task automatic clear_while_pending();
    icache_mon_t ic;
    dcache_mon_t dc;
    ic = '0;
    dc = '0;
    ic.req_valid = 1'b1;
    ic.req_ready = 1'b1;
    dc[2].req_valid = 1'b1;
    dc[2].req_ready = 1'b1;
    dc[3].req_valid = 1'b1;
    dc[3].req_ready = 1'b1;
    drive_cycle(ic, dc);
    idle_cycles(3);
    write_dcr(DCR_PERF_CLEAR, '0);
    // Store fire in the clear cycle is dropped
    dc = '0;
    dc[0].req_valid = 1'b1;
    dc[0].req_ready = 1'b1;
    dc[0].req_rw    = 1'b1;
    dcache_mon <= dc;
    idle_cycles(2);
    // Latency keeps growing from the pending reads during these reads
    read_all_counters();
    ic = '0;
    dc = '0;
    ic.rsp_valid = 1'b1;
    ic.rsp_ready = 1'b1;
    dc[2].rsp_valid = 1'b1;
    dc[2].rsp_ready = 1'b1;
    dc[3].rsp_valid = 1'b1;
    dc[3].rsp_ready = 1'b1;
    drive_cycle(ic, dc);
    idle_cycles(1);
    read_counter(RD_IFETCH_LAT, 0);
    read_counter(RD_LOAD_LAT, 0);
endtask

task automatic unknown_address_reads();
    icache_mon_t ic;
    for (int a = 5; a < 8; a++) begin
        read_counter(PERF_RD_ADDR_BITS'(a), 3);
    end
    // Fetch held outstanding so the latency sum moves while ack is high
    ic = '0;
    ic.req_valid = 1'b1;
    ic.req_ready = 1'b1;
    drive_cycle(ic, '0);
    idle_cycles(1);
    read_counter(RD_IFETCH_LAT, 2);
    ic = '0;
    ic.rsp_valid = 1'b1;
    ic.rsp_ready = 1'b1;
    drive_cycle(ic, '0);
    idle_cycles(1);
endtask

// ==== tb/tb_core_mem_perf.sv ====
`timescale 1ns/10ps

module tb_core_mem_perf;
    import perf_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int HANDSHAKE_LIMIT = 8;

    // Cycle budget of each directed test
    localparam int DISABLED_LEN = 120;
    localparam int TRAFFIC_LEN = 250;
    localparam int LATENCY_LEN = 60;
    localparam int CLEAR_LEN = 80;
    localparam int HANDSHAKE_LEN = 60;
    localparam int TEST_CYCLES = RESET_CYCLES + DISABLED_LEN + TRAFFIC_LEN + LATENCY_LEN
                                 + CLEAR_LEN + HANDSHAKE_LEN;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                         clk;
    logic                         reset;
    dcr_write_t                   dcr_write;
    icache_mon_t                  icache_mon;
    dcache_mon_t                  dcache_mon;
    logic                         perf_rd_req;
    logic [PERF_RD_ADDR_BITS-1:0] perf_rd_addr;
    logic                         perf_rd_ack;
    logic [PERF_RD_DATA_BITS-1:0] perf_rd_data;

    logic [31:0] rng_state;
    int          error_count;
    int          check_count;
    int          cycle_count;
    int          icache_outstanding;
    int          dcache_outstanding;

    // Reference model state
    logic [DCR_DATA_BITS-1:0] m_class;
    logic                     m_clear;
    longint                   m_ifetches;
    longint                   m_loads;
    longint                   m_stores;
    longint                   m_ifetch_lat;
    longint                   m_load_lat;
    int                       m_ipend;
    int                       m_dpend;

    core_mem_perf_top UUT (
        .clk          (clk),
        .reset        (reset),
        .dcr_write    (dcr_write),
        .icache_mon   (icache_mon),
        .dcache_mon   (dcache_mon),
        .perf_rd_req  (perf_rd_req),
        .perf_rd_addr (perf_rd_addr),
        .perf_rd_ack  (perf_rd_ack),
        .perf_rd_data (perf_rd_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, the tests did not finish", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // Model advances on the same edge as the DUT, from the driven stimulus
    always @(posedge clk) begin
        int ifire;
        int irsp;
        int rd_fires;
        int wr_fires;
        int rsp_fires;
        ifire = (icache_mon.req_valid && icache_mon.req_ready) ? 1 : 0;
        irsp = (icache_mon.rsp_valid && icache_mon.rsp_ready) ? 1 : 0;
        rd_fires = 0;
        wr_fires = 0;
        rsp_fires = 0;
        for (int i = 0; i < DCACHE_NUM_REQS; i++) begin
            if (dcache_mon[i].req_valid && dcache_mon[i].req_ready) begin
                if (dcache_mon[i].req_rw) begin
                    wr_fires++;
                end else begin
                    rd_fires++;
                end
            end
            if (dcache_mon[i].rsp_valid && dcache_mon[i].rsp_ready) begin
                rsp_fires++;
            end
        end
        if (reset) begin
            m_class <= '0;
            m_clear <= 1'b0;
            m_ifetches <= 0;
            m_loads <= 0;
            m_stores <= 0;
            m_ifetch_lat <= 0;
            m_load_lat <= 0;
            m_ipend <= 0;
            m_dpend <= 0;
        end else begin
            if (m_clear) begin
                m_ifetches <= 0;
                m_loads <= 0;
                m_stores <= 0;
                m_ifetch_lat <= 0;
                m_load_lat <= 0;
            end else if (m_class == MPM_CLASS_CORE) begin
                m_ifetches <= m_ifetches + ifire;
                m_loads <= m_loads + rd_fires;
                m_stores <= m_stores + wr_fires;
                m_ifetch_lat <= m_ifetch_lat + m_ipend;
                m_load_lat <= m_load_lat + m_dpend;
            end
            m_ipend <= m_ipend + ifire - irsp;
            m_dpend <= m_dpend + rd_fires - rsp_fires;
            if (dcr_write.valid && dcr_write.addr == DCR_MPM_CLASS) begin
                m_class <= dcr_write.data;
            end
            m_clear <= dcr_write.valid && (dcr_write.addr == DCR_PERF_CLEAR);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [PERF_RD_DATA_BITS-1:0] expected_count(
        input logic [PERF_RD_ADDR_BITS-1:0] addr
    );
        logic [PERF_CTR_BITS-1:0] v;
        case (addr)
            RD_IFETCHES:   v = m_ifetches[PERF_CTR_BITS-1:0];
            RD_LOADS:      v = m_loads[PERF_CTR_BITS-1:0];
            RD_STORES:     v = m_stores[PERF_CTR_BITS-1:0];
            RD_IFETCH_LAT: v = m_ifetch_lat[PERF_CTR_BITS-1:0];
            RD_LOAD_LAT:   v = m_load_lat[PERF_CTR_BITS-1:0];
            default:       v = '0;
        endcase
        return {{(PERF_RD_DATA_BITS-PERF_CTR_BITS){1'b0}}, v};
    endfunction

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        dcr_write = '0;
        icache_mon = '0;
        dcache_mon = '0;
        perf_rd_req = 1'b0;
        perf_rd_addr = '0;
        rng_state = 32'h704e16fc;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        icache_outstanding = 0;
        dcache_outstanding = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        counting_disabled();
        traffic_counts();
        latency_spans();
        clear_while_pending();
        unknown_address_reads();

        repeat (4) @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
